// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

FAIL_MSG := *** FAILED ***
PASS_MSG := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== project.f ====
rtl/i2c_pkg.sv
rtl/stream_pkg.sv
rtl/axis_if.sv
rtl/axis_fifo.sv
rtl/i2c_master.sv
rtl/i2c_bridge_top.sv
tests/tb_clock_gen.sv
tests/i2c_target_model.sv
tests/i2c_bridge_assertions.sv
tests/tb_top.sv

// ==== rtl/axis_fifo.sv ====
`timescale 1ns/100ps

module axis_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input logic clk_i,
    input logic arstn_i,

    axis_if.sink   in_s,
    axis_if.source out_m
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign wr_en = in_s.valid && in_s.ready;
    assign rd_en = out_m.valid && out_m.ready;

    assign in_s.ready  = (count != CNT_W'(DEPTH));  // Not full
    assign out_m.valid = (count != '0);
    assign out_m.data  = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_s.data;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
    end

    // Simultaneous write and read leaves the count unchanged
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            count <= '0;
        end else begin
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== rtl/axis_if.sv ====
`timescale 1ns/100ps

interface axis_if #(
    parameter type T = logic
) ();

    logic valid;
    logic ready;
    T     data;

    // Beat moves on a rising edge with valid and ready both high
    modport source (
        output valid,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        output ready
    );

endinterface

// ==== rtl/i2c_bridge_top.sv ====
`timescale 1ns/100ps

module i2c_bridge_top
    import i2c_pkg::*;
    import stream_pkg::*;
#(
    parameter int CLK_DIV    = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  arstn_i,

    input  logic                  cmd_valid_i,
    output logic                  cmd_ready_o,
    input  i2c_addr_t             cmd_addr_i,
    input  logic                  cmd_rw_i,
    input  logic [I2C_BYTE_W-1:0] cmd_wdata_i,

    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output logic [I2C_BYTE_W-1:0] rsp_rdata_o,
    output logic                  rsp_nack_o,

    output logic                  scl_o,
    output logic                  sda_oe_o,
    input  logic                  sda_i
);

    axis_if #(.T(i2c_cmd_t)) host_cmd ();
    axis_if #(.T(i2c_cmd_t)) cmd_stream ();
    axis_if #(.T(i2c_rsp_t)) rsp_stream ();
    axis_if #(.T(i2c_rsp_t)) host_rsp ();

    assign host_cmd.valid         = cmd_valid_i;
    assign host_cmd.data.address  = cmd_addr_i;
    assign host_cmd.data.rw       = i2c_rw_e'(cmd_rw_i);
    assign host_cmd.data.wdata    = cmd_wdata_i;
    assign cmd_ready_o            = host_cmd.ready;

    assign rsp_valid_o    = host_rsp.valid;
    assign rsp_rdata_o    = host_rsp.data.rdata;
    assign rsp_nack_o     = host_rsp.data.nack;
    assign host_rsp.ready = rsp_ready_i;

    axis_fifo #(.T(i2c_cmd_t), .DEPTH(FIFO_DEPTH)) cmd_fifo (
        .clk_i   (clk_i),
        .arstn_i (arstn_i),
        .in_s    (host_cmd),
        .out_m   (cmd_stream)
    );

    i2c_master #(.CLK_DIV(CLK_DIV)) master (
        .clk_i    (clk_i),
        .arstn_i  (arstn_i),
        .cmd_s    (cmd_stream),
        .rsp_m    (rsp_stream),
        .scl_o    (scl_o),
        .sda_oe_o (sda_oe_o),
        .sda_i    (sda_i)
    );

    axis_fifo #(.T(i2c_rsp_t), .DEPTH(FIFO_DEPTH)) rsp_fifo (
        .clk_i   (clk_i),
        .arstn_i (arstn_i),
        .in_s    (rsp_stream),
        .out_m   (host_rsp)
    );

endmodule

// ==== rtl/i2c_master.sv ====
`timescale 1ns/100ps

module i2c_master
    import i2c_pkg::*;
    import stream_pkg::*;
#(
    parameter int CLK_DIV = 4
) (
    input  logic clk_i,
    input  logic arstn_i,

    axis_if.sink   cmd_s,
    axis_if.source rsp_m,

    output logic scl_o,
    output logic sda_oe_o,
    input  logic sda_i
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int BIT_W = $clog2(I2C_BYTE_W);
    localparam int MSB   = I2C_BYTE_W - 1;

    i2c_state_e state;

    logic [DIV_W-1:0]      div_cnt;
    logic [1:0]            phase;      // Quarter of the current bit
    logic [BIT_W-1:0]      bit_cnt;
    logic [I2C_BYTE_W-1:0] shreg;
    logic [I2C_BYTE_W-1:0] wdata;
    i2c_rw_e               rw;
    logic                  nack;
    logic                  rsp_valid;
    i2c_rsp_t              rsp;

    logic busy;
    logic tick;
    logic bit_end;
    logic last_bit;
    logic cmd_fire;
    logic rsp_fire;
    logic sda_bit_oe;

    assign busy     = (state != ST_IDLE) && !rsp_valid;
    assign tick     = busy && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign bit_end  = tick && (phase == 2'd3);
    assign last_bit = (bit_cnt == BIT_W'(I2C_BYTE_W - 1));
    assign cmd_fire = cmd_s.valid && cmd_s.ready;
    assign rsp_fire = rsp_m.valid && rsp_m.ready;

    assign cmd_s.ready = (state == ST_IDLE);

    assign rsp.rdata   = ((rw == I2C_READ) && !nack) ? shreg : '0;
    assign rsp.nack    = nack;
    assign rsp_m.valid = rsp_valid;
    assign rsp_m.data  = rsp;

    // Quarter-bit tick divider, idle between transactions
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            div_cnt <= '0;
            phase   <= '0;
        end else if (!busy) begin
            div_cnt <= '0;
            phase   <= '0;
        end else if (tick) begin
            div_cnt <= '0;
            phase   <= phase + 2'd1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            state     <= ST_IDLE;
            bit_cnt   <= '0;
            nack      <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_fire) begin
                        state <= ST_START;
                        nack  <= 1'b0;
                    end
                end
                ST_START: begin
                    if (bit_end) begin
                        state   <= ST_ADDR;
                        bit_cnt <= '0;
                    end
                end
                ST_ADDR: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_bit) begin
                            state <= ST_ADDR_ACK;
                        end
                    end
                end
                ST_ADDR_ACK: begin
                    if (bit_end) begin
                        nack <= sda_i;
                        if (sda_i) begin
                            state <= ST_STOP;  // No target so the data byte is skipped
                        end else begin
                            state <= (rw == I2C_READ) ? ST_RD_DATA : ST_WR_DATA;
                        end
                    end
                end
                ST_WR_DATA, ST_RD_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_bit) begin
                            state <= ST_DATA_ACK;
                        end
                    end
                end
                ST_DATA_ACK: begin
                    if (bit_end) begin
                        if (rw == I2C_WRITE) begin
                            nack <= sda_i;
                        end
                        state <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    if (rsp_valid) begin
                        if (rsp_fire) begin
                            rsp_valid <= 1'b0;
                            state     <= ST_IDLE;
                        end
                    end else if (bit_end) begin
                        rsp_valid <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_fire) begin
            shreg <= {cmd_s.data.address, cmd_s.data.rw};
            wdata <= cmd_s.data.wdata;
            rw    <= cmd_s.data.rw;
        end else if (bit_end) begin
            case (state)
                ST_ADDR, ST_WR_DATA, ST_RD_DATA: shreg <= {shreg[MSB-1:0], sda_i};
                ST_ADDR_ACK:                     shreg <= wdata;
                default:                         shreg <= shreg;
            endcase
        end
    end

    // SDA level for the low half of SCL
    always_comb begin
        case (state)
            ST_START, ST_STOP:     sda_bit_oe = 1'b1;
            ST_ADDR, ST_WR_DATA:   sda_bit_oe = ~shreg[MSB];
            default:               sda_bit_oe = 1'b0;  // Ack slots, read bits, master NACK
        endcase
    end

    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            sda_oe_o <= 1'b0;
        end else if (tick && (phase == 2'd1)) begin
            sda_oe_o <= sda_bit_oe;
        end else if (bit_end && (state == ST_STOP)) begin
            sda_oe_o <= 1'b0;  // SDA rises with SCL high
        end
    end

    // SCL stays high through the start bit
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            scl_o <= 1'b1;
        end else if (tick && (state != ST_START)) begin
            if (phase == 2'd0) begin
                scl_o <= 1'b0;
            end else if (phase == 2'd2) begin
                scl_o <= 1'b1;
            end
        end
    end

endmodule

// ==== rtl/i2c_pkg.sv ====
package i2c_pkg;

    localparam int I2C_BYTE_W = 8;  // Bits per bus byte
    localparam int I2C_ADDR_W = 7;

    typedef logic [I2C_ADDR_W-1:0] i2c_addr_t;

    // Direction bit that follows the address on the bus
    typedef enum logic {
        I2C_WRITE = 1'b0,
        I2C_READ  = 1'b1
    } i2c_rw_e;

    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_START    = 3'd1,
        ST_ADDR     = 3'd2,
        ST_ADDR_ACK = 3'd3,
        ST_WR_DATA  = 3'd4,
        ST_RD_DATA  = 3'd5,
        ST_DATA_ACK = 3'd6,
        ST_STOP     = 3'd7
    } i2c_state_e;

endpackage

// ==== rtl/stream_pkg.sv ====
package stream_pkg;

    import i2c_pkg::*;

    // One single-byte bus transaction
    typedef struct packed {
        i2c_addr_t             address;
        i2c_rw_e               rw;
        logic [I2C_BYTE_W-1:0] wdata;
    } i2c_cmd_t;

    typedef struct packed {
        logic [I2C_BYTE_W-1:0] rdata;  // Zero unless an acknowledged read
        logic                  nack;   // Address or write byte not acknowledged
    } i2c_rsp_t;

endpackage

// ==== tests/i2c_bridge_assertions.sv ====
`timescale 1ns/100ps

module i2c_bridge_assertions
    import i2c_pkg::*;
(
    input logic                  clk_i,
    input logic                  arstn_i,
    input logic                  cmd_ready_i,
    input logic                  rsp_valid_i,
    input logic                  rsp_ready_i,
    input logic [I2C_BYTE_W-1:0] rsp_rdata_i,
    input logic                  rsp_nack_i,
    input logic                  scl_i,
    input logic                  sda_oe_i,
    input logic                  sda_i,
    input i2c_state_e            state_i
);

    int fail_count = 0;

    reset_values: assert property (@(posedge clk_i)
        !arstn_i |-> (cmd_ready_i && !rsp_valid_i && scl_i && !sda_oe_i))
        else begin
            fail_count = fail_count + 1;
            $error("Outputs are not at their reset values during reset");
        end

    // With SCL high only a start or a stop may move SDA
    sda_stable_scl_high: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (scl_i && $past(scl_i) && (sda_i != $past(sda_i))) |->
            ((!sda_i && (state_i == ST_START)) || (sda_i && (state_i == ST_STOP))))
        else begin
            fail_count = fail_count + 1;
            $error("SDA changed while SCL was high outside a start or stop");
        end

    idle_sda_released: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (state_i == ST_IDLE) |-> !sda_oe_i)
        else begin
            fail_count = fail_count + 1;
            $error("SDA driven low while the master is idle");
        end

    rsp_held_under_stall: assert property (@(posedge clk_i) disable iff (!arstn_i)
        (rsp_valid_i && !rsp_ready_i) |=>
            (rsp_valid_i && ({rsp_rdata_i, rsp_nack_i} == $past({rsp_rdata_i, rsp_nack_i}))))
        else begin
            fail_count = fail_count + 1;
            $error("Response changed or dropped while stalled");
        end

endmodule

bind i2c_bridge_top i2c_bridge_assertions assertions (
    .clk_i       (clk_i),
    .arstn_i     (arstn_i),
    .cmd_ready_i (cmd_ready_o),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_i (rsp_rdata_o),
    .rsp_nack_i  (rsp_nack_o),
    .scl_i       (scl_o),
    .sda_oe_i    (sda_oe_o),
    .sda_i       (sda_i),
    .state_i     (master.state)
);

// ==== tests/i2c_target_model.sv ====
`timescale 1ns/100ps

module i2c_target_model
    import i2c_pkg::*;
#(
    parameter i2c_addr_t ADDR = 7'h50
) (
    input  logic clk_i,
    input  logic arstn_i,
    input  logic scl_i,
    input  logic sda_i,
    output logic sda_rel_o   // Low pulls SDA down
);

    logic       scl_q;
    logic       sda_q;
    logic       active;
    logic       addressed;
    logic       reading;
    logic       byte_idx;    // 0 for the address byte, 1 for the data byte
    logic [3:0] bit_cnt;
    logic [7:0] shreg;
    logic [7:0] reg_q;

    // Bus edges are found by oversampling with the system clock
    always_ff @(posedge clk_i or negedge arstn_i) begin
        if (!arstn_i) begin
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            active    <= 1'b0;
            addressed <= 1'b0;
            reading   <= 1'b0;
            byte_idx  <= 1'b0;
            bit_cnt   <= '0;
            shreg     <= '0;
            reg_q     <= '0;
            sda_rel_o <= 1'b1;
        end else begin
            scl_q <= scl_i;
            sda_q <= sda_i;
            if (scl_i && scl_q && sda_q && !sda_i) begin  // Start
                active    <= 1'b1;
                addressed <= 1'b0;
                byte_idx  <= 1'b0;
                bit_cnt   <= '0;
            end else if (scl_i && scl_q && !sda_q && sda_i) begin  // Stop
                active    <= 1'b0;
                sda_rel_o <= 1'b1;
            end else if (active && scl_i && !scl_q) begin
                if (bit_cnt < 4'd8) begin
                    shreg <= {shreg[6:0], sda_i};
                end
                bit_cnt <= bit_cnt + 4'd1;
            end else if (active && !scl_i && scl_q) begin
                sda_rel_o <= 1'b1;
                if (bit_cnt == 4'd8) begin
                    if (!byte_idx && (shreg[7:1] == ADDR)) begin
                        addressed <= 1'b1;
                        reading   <= shreg[0];
                        sda_rel_o <= 1'b0;
                    end else if (byte_idx && addressed && !reading) begin
                        reg_q     <= shreg;
                        sda_rel_o <= 1'b0;
                    end
                end else if (bit_cnt == 4'd9) begin
                    bit_cnt  <= '0;
                    byte_idx <= 1'b1;
                    if (!byte_idx && addressed && reading) begin
                        sda_rel_o <= reg_q[7];  // First read bit, MSB first
                    end
                end else if (byte_idx && addressed && reading && (bit_cnt != 4'd0)) begin
                    sda_rel_o <= reg_q[3'd7 - bit_cnt[2:0]];
                end
            end
        end
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic arstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset falls shortly after time zero so the async reset sees a real edge
    initial begin
        arstn_o = 1'b1;
        #1;
        arstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arstn_o = 1'b1;
    end

endmodule

// ==== tests/tb_top.sv ====
`timescale 1ns/100ps

module tb_top
    import i2c_pkg::*;
    import stream_pkg::*;
();

    localparam i2c_addr_t TARGET_ADDR    = 7'h50;
    localparam int        LCG_SEED       = 38;
    localparam int        N_CMDS         = 16;   // First four are directed
    localparam int        TIMEOUT_CYCLES = 2000;
    localparam int        IDLE_CYCLES    = 400;

    logic       clk;
    logic       arstn;
    logic       cmd_valid;
    logic       cmd_ready;
    i2c_addr_t  cmd_addr;
    logic       cmd_rw;
    logic [7:0] cmd_wdata;
    logic       rsp_valid;
    logic       rsp_ready;
    logic [7:0] rsp_rdata;
    logic       rsp_nack;
    logic       scl;
    logic       sda_oe;
    logic       sda;
    logic       target_rel;

    logic [31:0] rng_cmd   = LCG_SEED;
    logic [31:0] rng_stall = LCG_SEED + 1;
    logic [7:0]  target_byte = 8'h00;   // Last byte written to the target
    i2c_rsp_t    expected_q[$];
    int          errors       = 0;
    int          timeouts     = 0;
    int          assert_fails = 0;

    assign sda = ~sda_oe & target_rel;  // Wired-AND bus

    tb_clock_gen clock_gen (.clk_o(clk), .arstn_o(arstn));

    i2c_bridge_top #(.CLK_DIV(2)) dut (
        .clk_i       (clk),
        .arstn_i     (arstn),
        .cmd_valid_i (cmd_valid),
        .cmd_ready_o (cmd_ready),
        .cmd_addr_i  (cmd_addr),
        .cmd_rw_i    (cmd_rw),
        .cmd_wdata_i (cmd_wdata),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .rsp_rdata_o (rsp_rdata),
        .rsp_nack_o  (rsp_nack),
        .scl_o       (scl),
        .sda_oe_o    (sda_oe),
        .sda_i       (sda)
    );

    i2c_target_model #(.ADDR(TARGET_ADDR)) target (
        .clk_i     (clk),
        .arstn_i   (arstn),
        .scl_i     (scl),
        .sda_i     (sda),
        .sda_rel_o (target_rel)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic pick_command(input int idx, output i2c_addr_t addr, output logic rw,
                                output logic [7:0] wdata);
        rng_cmd = lcg_step(rng_cmd);
        addr    = rng_cmd[28] ? TARGET_ADDR : rng_cmd[26:20];
        rw      = rng_cmd[29];
        wdata   = rng_cmd[19:12];
        case (idx)
            0: begin
                addr  = TARGET_ADDR;
                rw    = 1'b0;
                wdata = 8'hA5;
            end
            1: begin
                addr = TARGET_ADDR;
                rw   = 1'b1;
            end
            2: begin
                addr = TARGET_ADDR ^ 7'h08;  // Nobody answers here
                rw   = 1'b0;
            end
            3: begin
                addr = 7'h13;
                rw   = 1'b1;
            end
            default: ;
        endcase
    endtask

    // Only the target address acks and reads return the last write
    task automatic record_expected(input i2c_addr_t addr, input logic rw, input logic [7:0] wdata);
        i2c_rsp_t exp;
        exp.nack  = (addr != TARGET_ADDR);
        exp.rdata = (!exp.nack && rw) ? target_byte : 8'h00;
        if (!exp.nack && !rw) begin
            target_byte = wdata;
        end
        expected_q.push_back(exp);
    endtask

    task automatic send_commands();
        i2c_addr_t  addr;
        logic       rw;
        logic [7:0] wdata;
        int         waited;
        for (int i = 0; i < N_CMDS; i++) begin
            pick_command(i, addr, rw, wdata);
            cmd_valid = 1'b1;
            cmd_addr  = addr;
            cmd_rw    = rw;
            cmd_wdata = wdata;
            waited    = 0;
            while (!cmd_ready && (waited < TIMEOUT_CYCLES)) begin
                @(negedge clk);
                waited++;
            end
            assert (cmd_ready) else begin
                timeouts++;
                $display("Timed out: command %0d was never accepted", i);
            end
            record_expected(addr, rw, wdata);
            @(negedge clk);  // Beat taken on the rising edge in between
        end
        cmd_valid = 1'b0;
    endtask

    task automatic collect_responses();
        i2c_rsp_t exp;
        int       waited;
        for (int i = 0; i < N_CMDS; i++) begin
            waited = 0;
            do begin
                @(negedge clk);
                rng_stall = lcg_step(rng_stall);
                rsp_ready = rng_stall[21];  // Stalls about half the time
                waited++;
            end while (!(rsp_valid && rsp_ready) && (waited < TIMEOUT_CYCLES));
            if (!(rsp_valid && rsp_ready)) begin
                timeouts++;
                $display("Timed out waiting for response %0d", i);
            end else if (expected_q.size() == 0) begin
                errors++;
                $display("Response %0d arrived with no command outstanding", i);
            end else begin
                exp = expected_q.pop_front();
                assert (rsp_nack == exp.nack) else begin
                    errors++;
                    $display("CHECK FAILED rsp_nack_o: got %h, expected %h", rsp_nack, exp.nack);
                end
                assert (rsp_rdata == exp.rdata) else begin
                    errors++;
                    $display("CHECK FAILED rsp_rdata_o: got %h, expected %h", rsp_rdata,
                             exp.rdata);
                end
            end
        end
    endtask

    initial begin
        int waited;
        cmd_valid = 1'b0;
        cmd_addr  = '0;
        cmd_rw    = 1'b0;
        cmd_wdata = '0;
        rsp_ready = 1'b0;
        waited    = 0;
        @(negedge clk);
        while (!arstn && (waited < 100)) begin
            @(negedge clk);
            waited++;
        end
        assert (arstn) else begin
            timeouts++;
            $display("Timed out waiting for reset to be released");
        end
        fork
            send_commands();
            collect_responses();
        join
        rsp_ready = 1'b1;
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            assert (!rsp_valid) else begin
                errors++;
                $display("A response arrived beyond one per command");
            end
        end
        assert (expected_q.size() == 0) else begin
            errors++;
            $display("Commands were left without a response");
        end
        assert_fails = dut.assertions.fail_count;
        $display("Check failures: %0d, timeouts: %0d, assertion failures: %0d",
                 errors, timeouts, assert_fails);
        if ((errors == 0) && (timeouts == 0) && (assert_fails == 0)) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
